/* Bender.yml */
package:
  name: fpu

sources:
  - files:
      - logic/fpu_pkg.sv
      - logic/fpu_result_if.sv
      - logic/fp_addsub.sv
      - logic/fp_mult.sv
      - logic/fp_unary.sv
      - logic/fpu.sv
  - target: test
    files:
      - testbench/fpu_tb.sv

/* all.f */
logic/fpu_pkg.sv
logic/fpu_result_if.sv
logic/fp_addsub.sv
logic/fp_mult.sv
logic/fp_unary.sv
logic/fpu.sv
testbench/fpu_tb.sv

/* logic/fp_addsub.sv */
module fp_addsub (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  input  logic        sub_i,
  fpu_result_if.unit  res_o
);
  import fpu_pkg::*;

  fp_word_u          a;
  fp_word_u          b;
  logic              in_nan;
  logic              in_inf;
  fp_word_u          s1_l;
  fp_word_u          s1_s;
  logic              s1_nan;
  logic              s1_inf;
  logic              s1_inf_sign;
  logic [7:0]        shamt;
  logic [49:0]       shifted;
  logic [26:0]       aligned;
  logic [27:0]       sum;
  logic [27:0]       s2_sum;
  logic [7:0]        s2_exp;
  logic              s2_sign;
  logic              s2_zero_sign;
  logic              s2_nan;
  logic              s2_inf;
  logic              s2_inf_sign;
  logic [4:0]        lz;
  logic [27:0]       norm;
  logic signed [9:0] exp_n;
  fp_word_u          res;
  logic              ovf;
  logic              unf;

  assign a = a_i;

  // subtract folds into the sign of b.
  always_comb begin
    b = b_i;
    b.f.sign = b_i[31] ^ sub_i;
  end

  assign in_inf = fp_is_inf(a) | fp_is_inf(b);
  assign in_nan = fp_is_nan(a) | fp_is_nan(b) |
                  (fp_is_inf(a) & fp_is_inf(b) & (a.f.sign ^ b.f.sign));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_l        <= '0;
      s1_s        <= '0;
      s1_nan      <= 1'b0;
      s1_inf      <= 1'b0;
      s1_inf_sign <= 1'b0;
    end else begin
      // larger magnitude first.
      if (a.raw[30:0] >= b.raw[30:0]) begin
        s1_l <= a;
        s1_s <= b;
      end else begin
        s1_l <= b;
        s1_s <= a;
      end
      s1_nan      <= in_nan;
      s1_inf      <= in_inf;
      s1_inf_sign <= fp_is_inf(a) ? a.f.sign : b.f.sign;
    end
  end

  // shifts past 27 only feed the sticky bit.
  assign shamt = ((s1_l.f.exp - s1_s.f.exp) > 8'd27) ? 8'd27 : (s1_l.f.exp - s1_s.f.exp);
  assign shifted = {fp_mant(s1_s), 26'h0} >> shamt;
  assign aligned = {shifted[49:24], |shifted[23:0]};
  assign sum = (s1_l.f.sign ^ s1_s.f.sign) ?
               {1'b0, fp_mant(s1_l), 3'b000} - {1'b0, aligned} :
               {1'b0, fp_mant(s1_l), 3'b000} + {1'b0, aligned};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s2_sum       <= '0;
      s2_exp       <= '0;
      s2_sign      <= 1'b0;
      s2_zero_sign <= 1'b0;
      s2_nan       <= 1'b0;
      s2_inf       <= 1'b0;
      s2_inf_sign  <= 1'b0;
    end else begin
      s2_sum       <= sum;
      s2_exp       <= s1_l.f.exp;
      s2_sign      <= s1_l.f.sign;
      s2_zero_sign <= s1_l.f.sign & s1_s.f.sign;
      s2_nan       <= s1_nan;
      s2_inf       <= s1_inf;
      s2_inf_sign  <= s1_inf_sign;
    end
  end

  always_comb begin
    lz = 5'd0;
    for (int i = 0; i < 28; i++) begin
      if (s2_sum[i]) begin
        lz = 5'(27 - i);
      end
    end
  end

  assign norm  = s2_sum << lz;
  assign exp_n = $signed({2'b00, s2_exp}) + 10'sd1 - $signed({5'b00000, lz});

  always_comb begin
    res.raw = 32'h0;
    ovf     = 1'b0;
    unf     = 1'b0;
    if (s2_nan) begin
      res.raw = FP_QNAN;
    end else if (s2_inf) begin
      res.f.sign = s2_inf_sign;
      res.f.exp  = FP_EXP_INF;
    end else if (s2_sum == '0) begin
      res.f.sign = s2_zero_sign;
    end else if (exp_n >= 10'sd255) begin
      res.f.sign = s2_sign;
      res.f.exp  = FP_EXP_INF;
      ovf        = 1'b1;
    end else if (exp_n <= 10'sd0) begin
      res.f.sign = s2_sign;
      unf        = 1'b1;
    end else begin
      res.f.sign = s2_sign;
      res.f.exp  = exp_n[7:0];
      res.f.frac = norm[26:4];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_o.result    <= '0;
      res_o.nan       <= 1'b0;
      res_o.overflow  <= 1'b0;
      res_o.underflow <= 1'b0;
    end else begin
      res_o.result    <= res.raw;
      res_o.nan       <= s2_nan;
      res_o.overflow  <= ovf;
      res_o.underflow <= unf;
    end
  end

endmodule

/* logic/fp_mult.sv */
module fp_mult (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  fpu_result_if.unit  res_o
);
  import fpu_pkg::*;

  fp_word_u          a;
  fp_word_u          b;
  logic              in_zero;
  logic              in_inf;
  logic              s1_sign;
  logic signed [9:0] s1_exp;
  logic [23:0]       s1_man_a;
  logic [23:0]       s1_man_b;
  logic              s1_nan;
  logic              s1_inf;
  logic              s1_zero;
  logic [47:0]       s2_prod;
  logic              s2_sign;
  logic signed [9:0] s2_exp;
  logic              s2_nan;
  logic              s2_inf;
  logic              s2_zero;
  logic signed [9:0] exp_n;
  fp_word_u          res;
  logic              ovf;
  logic              unf;

  assign a = a_i;
  assign b = b_i;

  assign in_zero = fp_is_zero(a) | fp_is_zero(b);
  assign in_inf  = fp_is_inf(a) | fp_is_inf(b);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_sign  <= 1'b0;
      s1_exp   <= '0;
      s1_man_a <= '0;
      s1_man_b <= '0;
      s1_nan   <= 1'b0;
      s1_inf   <= 1'b0;
      s1_zero  <= 1'b0;
    end else begin
      s1_sign  <= a.f.sign ^ b.f.sign;
      s1_exp   <= $signed({2'b00, a.f.exp}) + $signed({2'b00, b.f.exp}) - 10'(FP_EXP_BIAS);
      s1_man_a <= fp_mant(a);
      s1_man_b <= fp_mant(b);
      // zero times infinity is invalid.
      s1_nan   <= fp_is_nan(a) | fp_is_nan(b) | (in_inf & in_zero);
      s1_inf   <= in_inf;
      s1_zero  <= in_zero;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s2_prod <= '0;
      s2_sign <= 1'b0;
      s2_exp  <= '0;
      s2_nan  <= 1'b0;
      s2_inf  <= 1'b0;
      s2_zero <= 1'b0;
    end else begin
      s2_prod <= s1_man_a * s1_man_b;
      s2_sign <= s1_sign;
      s2_exp  <= s1_exp;
      s2_nan  <= s1_nan;
      s2_inf  <= s1_inf;
      s2_zero <= s1_zero;
    end
  end

  // product in [1,4), at most one bit to renormalize.
  assign exp_n = s2_exp + $signed({9'h000, s2_prod[47]});

  always_comb begin
    res.raw    = 32'h0;
    res.f.sign = s2_sign;
    ovf        = 1'b0;
    unf        = 1'b0;
    if (s2_nan) begin
      res.raw = FP_QNAN;
    end else if (s2_inf) begin
      res.f.exp = FP_EXP_INF;
    end else if (s2_zero) begin
      res.f.exp = 8'h00;
    end else if (exp_n >= 10'sd255) begin
      res.f.exp = FP_EXP_INF;
      ovf       = 1'b1;
    end else if (exp_n <= 10'sd0) begin
      unf = 1'b1;
    end else begin
      res.f.exp  = exp_n[7:0];
      res.f.frac = s2_prod[47] ? s2_prod[46:24] : s2_prod[45:23];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_o.result    <= '0;
      res_o.nan       <= 1'b0;
      res_o.overflow  <= 1'b0;
      res_o.underflow <= 1'b0;
    end else begin
      res_o.result    <= res.raw;
      res_o.nan       <= s2_nan;
      res_o.overflow  <= ovf;
      res_o.underflow <= unf;
    end
  end

endmodule

/* logic/fp_unary.sv */
module fp_unary (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [31:0]        a_i,
  input  fpu_pkg::fpu_func_e func_i,
  fpu_result_if.unit         res_o
);
  import fpu_pkg::*;

  fpu_func_e         s1_func;
  fp_word_u          s1_word;
  logic [31:0]       s1_mag;
  logic [4:0]        lead;
  logic signed [9:0] exp_unb;
  logic              zero_n;
  logic              sat_n;
  logic [7:0]        exp_n;
  logic [31:0]       val_n;
  fpu_func_e         s2_func;
  logic              s2_sign;
  logic              s2_zero;
  logic              s2_sat;
  logic [7:0]        s2_exp;
  logic [31:0]       s2_val;
  fp_word_u          res;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_func <= FPU_CVTIS;
      s1_word <= '0;
      s1_mag  <= '0;
    end else begin
      s1_func <= func_i;
      s1_word <= a_i;
      // magnitude of the signed integer view.
      s1_mag  <= a_i[31] ? -a_i : a_i;
    end
  end

  always_comb begin
    lead = 5'd0;
    for (int i = 0; i < 32; i++) begin
      if (s1_mag[i]) begin
        lead = 5'(i);
      end
    end
  end

  assign exp_unb = $signed({2'b00, s1_word.f.exp}) - 10'(FP_EXP_BIAS);

  always_comb begin
    zero_n = 1'b0;
    sat_n  = 1'b0;
    exp_n  = 8'h00;
    val_n  = 32'h0;
    case (s1_func)
      FPU_CVTIS: begin
        zero_n = (s1_mag == '0);
        exp_n  = 8'(FP_EXP_BIAS) + {3'b000, lead};
        val_n  = s1_mag << (5'd31 - lead);
      end
      FPU_CVTSI: begin
        if (fp_is_nan(s1_word) || fp_is_zero(s1_word) || (exp_unb < 10'sd0)) begin
          zero_n = 1'b1;
        end else if (exp_unb > 10'sd30) begin
          sat_n = 1'b1;
        end else if (exp_unb >= 10'sd23) begin
          val_n = {8'h00, fp_mant(s1_word)} << (exp_unb[4:0] - 5'd23);
        end else begin
          val_n = {8'h00, fp_mant(s1_word)} >> (5'd23 - exp_unb[4:0]);
        end
      end
      FPU_NEG: begin
        val_n = s1_word.raw ^ 32'h8000_0000;
      end
      default: begin
        val_n = 32'h0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s2_func <= FPU_CVTIS;
      s2_sign <= 1'b0;
      s2_zero <= 1'b1;
      s2_sat  <= 1'b0;
      s2_exp  <= '0;
      s2_val  <= '0;
    end else begin
      s2_func <= s1_func;
      s2_sign <= s1_word.f.sign;
      s2_zero <= zero_n;
      s2_sat  <= sat_n;
      s2_exp  <= exp_n;
      s2_val  <= val_n;
    end
  end

  always_comb begin
    res.raw = 32'h0;
    case (s2_func)
      FPU_CVTIS: begin
        if (!s2_zero) begin
          res.f.sign = s2_sign;
          res.f.exp  = s2_exp;
          res.f.frac = s2_val[30:8];
        end
      end
      FPU_CVTSI: begin
        if (s2_sat) begin
          res.raw = s2_sign ? 32'h8000_0000 : 32'h7fff_ffff;
        end else if (!s2_zero) begin
          res.raw = s2_sign ? -s2_val : s2_val;
        end
      end
      FPU_NEG: begin
        res.raw = s2_val;
      end
      default: begin
        res.raw = 32'h0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_o.result <= '0;
    end else begin
      res_o.result <= res.raw;
    end
  end

  // conversions and negate never flag.
  assign res_o.nan       = 1'b0;
  assign res_o.overflow  = 1'b0;
  assign res_o.underflow = 1'b0;

endmodule

/* logic/fpu.sv */
module fpu (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [31:0]        in1_i,
  input  logic [31:0]        in2_i,
  input  fpu_pkg::fpu_func_e func_i,
  output logic [31:0]        out_o,
  output logic               overflow_o,
  output logic               underflow_o,
  output logic               nan_o
);
  import fpu_pkg::*;

  fpu_func_e func_q [FPU_LATENCY];

  fpu_result_if addsub_if ();
  fpu_result_if mult_if ();
  fpu_result_if unary_if ();

  // function code follows its operands down the pipe.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < FPU_LATENCY; i++) begin
        func_q[i] <= FPU_CVTIS;
      end
    end else begin
      func_q[0] <= func_i;
      for (int i = 1; i < FPU_LATENCY; i++) begin
        func_q[i] <= func_q[i-1];
      end
    end
  end

  always_comb begin
    out_o       = 32'h0;
    overflow_o  = 1'b0;
    underflow_o = 1'b0;
    nan_o       = 1'b0;
    case (func_q[FPU_LATENCY-1])
      FPU_ADD, FPU_SUB: begin
        out_o       = addsub_if.result;
        overflow_o  = addsub_if.overflow;
        underflow_o = addsub_if.underflow;
        nan_o       = addsub_if.nan;
      end
      FPU_MUL: begin
        out_o       = mult_if.result;
        overflow_o  = mult_if.overflow;
        underflow_o = mult_if.underflow;
        nan_o       = mult_if.nan;
      end
      FPU_CVTIS, FPU_CVTSI, FPU_NEG: begin
        out_o       = unary_if.result;
        overflow_o  = unary_if.overflow;
        underflow_o = unary_if.underflow;
        nan_o       = unary_if.nan;
      end
      // sqrt and div are reserved.
      default: begin
        out_o = 32'h0;
      end
    endcase
  end

  fp_addsub fp_addsub0 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .a_i   (in1_i),
    .b_i   (in2_i),
    .sub_i (func_i[0]),
    .res_o (addsub_if.unit)
  );

  fp_mult fp_mult0 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .a_i   (in1_i),
    .b_i   (in2_i),
    .res_o (mult_if.unit)
  );

  // single operand functions take in2.
  fp_unary fp_unary0 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .a_i    (in2_i),
    .func_i (func_i),
    .res_o  (unary_if.unit)
  );

endmodule

/* logic/fpu_pkg.sv */
package fpu_pkg;

  // function codes as issued by the CPU.
  typedef enum logic [2:0] {
    FPU_CVTIS = 3'd0,
    FPU_CVTSI = 3'd1,
    FPU_SQRT  = 3'd2,
    FPU_NEG   = 3'd3,
    FPU_ADD   = 3'd4,
    FPU_SUB   = 3'd5,
    FPU_MUL   = 3'd6,
    FPU_DIV   = 3'd7
  } fpu_func_e;

  // cycles from operands to result.
  localparam int FPU_LATENCY = 3;

  localparam int FP_EXP_BIAS = 127;

  localparam logic [7:0] FP_EXP_INF = 8'hff;

  localparam logic [31:0] FP_QNAN = 32'h7fc0_0000;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] frac;
  } fp_fields_t;

  // one word, read as float fields or as a plain integer.
  typedef union packed {
    fp_fields_t  f;
    logic [31:0] raw;
  } fp_word_u;

  function automatic logic fp_is_nan(fp_word_u w);
    return (w.f.exp == FP_EXP_INF) && (w.f.frac != '0);
  endfunction

  function automatic logic fp_is_inf(fp_word_u w);
    return (w.f.exp == FP_EXP_INF) && (w.f.frac == '0);
  endfunction

  // subnormals are taken as zero.
  function automatic logic fp_is_zero(fp_word_u w);
    return w.f.exp == 8'h00;
  endfunction

  // mantissa with the hidden bit, zero for zero and subnormal inputs.
  function automatic logic [23:0] fp_mant(fp_word_u w);
    return (w.f.exp == 8'h00) ? 24'h0 : {1'b1, w.f.frac};
  endfunction

endpackage

/* logic/fpu_result_if.sv */
interface fpu_result_if;

  logic [31:0] result;
  logic        nan;
  logic        overflow;
  logic        underflow;

  modport unit (
    output result,
    output nan,
    output overflow,
    output underflow
  );

  modport sel (
    input result,
    input nan,
    input overflow,
    input underflow
  );

endinterface

/* testbench/fpu_stim.txt */
// func in1 in2 expected_out flags, all hex.
// flags bit 2 overflow, bit 1 underflow, bit 0 nan.
4 3f800000 40000000 40400000 0
4 3f800000 34400000 3f800001 0
5 40400000 3f800000 40000000 0
5 40200000 40200000 00000000 0
5 3f800000 33000000 3f7fffff 0
5 7f800000 7f800000 7fc00000 1
4 7f7fffff 7f7fffff 7f800000 4
5 00800001 00800000 00000000 2
4 7f800001 3f800000 7fc00000 1
6 3dcccccd 40400000 3e999999 0
6 40400000 40400000 41100000 0
6 ff000000 40000000 ff800000 4
6 80800000 3f000000 80000000 2
6 00000000 7f800000 7fc00000 1
6 c0000000 00000000 80000000 0
0 00000000 00000000 00000000 0
0 12345678 fffffffb c0a00000 0
0 00000000 01000001 4b800000 0
0 00000000 fefffffd cb800001 0
0 00000000 7fffffff 4effffff 0
1 00000000 40700000 00000003 0
1 00000000 c0200000 fffffffe 0
1 00000000 501502f9 7fffffff 0
1 00000000 cf32d05e 80000000 0
1 00000000 7fc00000 00000000 0
1 00000000 3f000000 00000000 0
3 00000000 3f800000 bf800000 0
3 00000000 7fc00000 ffc00000 0
2 40800000 40800000 00000000 0
7 3f800000 00000000 00000000 0
// mixed functions, back to back.
6 3fc00000 40000000 40400000 0
4 3fc00000 40200000 40800000 0
0 00000000 80000000 cf000000 0
5 3f800000 3fc00000 bf000000 0
3 00000000 00000001 80000001 0
1 00000000 4b800001 01000002 0
7 40000000 40000000 00000000 0
4 7f800000 3f800000 7f800000 0

/* testbench/fpu_tb.sv */
module fpu_tb;
  import fpu_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_OPS      = 64;
  localparam int WORDS_PER_OP = 5;
  localparam int MAX_GAP      = 2;
  // the last lines of the stimulus file run with no idle cycles.
  localparam int BURST_OPS    = 8;

  typedef struct packed {
    logic [31:0] due;
    logic [31:0] out;
    logic [3:0]  flags;
  } expect_t;

  logic        clk;
  logic        rst_i;
  logic [31:0] in1_i;
  logic [31:0] in2_i;
  fpu_func_e   func_i;
  logic [31:0] out_o;
  logic        overflow_o;
  logic        underflow_o;
  logic        nan_o;

  logic [31:0] stim [MAX_OPS * WORDS_PER_OP];
  expect_t     exp_q [$];
  expect_t     head;
  int          cycle_cnt = 0;
  int          n_ops     = 0;
  int          run_limit = 0;
  int          checks    = 0;
  int          errors    = 0;

  fpu dut (
    .clk_i       (clk),
    .rst_i       (rst_i),
    .in1_i       (in1_i),
    .in2_i       (in2_i),
    .func_i      (func_i),
    .out_o       (out_o),
    .overflow_o  (overflow_o),
    .underflow_o (underflow_o),
    .nan_o       (nan_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error: %s is %h, expected %h at time %0t", name, actual, expected, $time);
    end
  endtask

  // drive one operation and queue its result for three cycles later.
  task automatic drive_op(input logic [2:0] func, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] exp_out,
                          input logic [3:0] flags);
    expect_t e;
    @(posedge clk);
    func_i  <= fpu_func_e'(func);
    in1_i   <= a;
    in2_i   <= b;
    e.due   = cycle_cnt + FPU_LATENCY + 1;
    e.out   = exp_out;
    e.flags = flags;
    exp_q.push_back(e);
  endtask

  function automatic int count_ops();
    int n;
    n = 0;
    while (n < MAX_OPS && stim[n * WORDS_PER_OP] !== 'x) begin
      n++;
    end
    return n;
  endfunction

  task automatic run_stimulus();
    expect_t e;
    int      gap;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
    // cleared pipeline gives zero for the first cycles.
    for (int i = 1; i <= FPU_LATENCY; i++) begin
      e.due   = cycle_cnt + i;
      e.out   = 32'h0;
      e.flags = 4'h0;
      exp_q.push_back(e);
    end
    for (int i = 0; i < n_ops; i++) begin
      drive_op(stim[i * WORDS_PER_OP][2:0], stim[i * WORDS_PER_OP + 1],
               stim[i * WORDS_PER_OP + 2], stim[i * WORDS_PER_OP + 3],
               stim[i * WORDS_PER_OP + 4][3:0]);
      if (i < n_ops - BURST_OPS) begin
        gap = $urandom % (MAX_GAP + 1);
        // idle slots carry a reserved code, which must read as zero.
        repeat (gap) drive_op(FPU_SQRT, 32'h0, 32'h0, 32'h0, 4'h0);
      end
    end
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // outputs are stable at the falling edge.
  always @(negedge clk) begin
    while (exp_q.size() != 0 && exp_q[0].due == cycle_cnt) begin
      head = exp_q.pop_front();
      check_value("out_o", out_o, head.out);
      check_value("overflow_o", {31'h0, overflow_o}, {31'h0, head.flags[2]});
      check_value("underflow_o", {31'h0, underflow_o}, {31'h0, head.flags[1]});
      check_value("nan_o", {31'h0, nan_o}, {31'h0, head.flags[0]});
    end
  end

  initial begin
    void'($urandom(32'h35ba));
    clk    = 1'b0;
    rst_i  = 1'b1;
    // an overflowing multiply sits on the inputs through reset.
    in1_i  = 32'h7f7f_ffff;
    in2_i  = 32'h7f7f_ffff;
    func_i = FPU_MUL;
    $readmemh("testbench/fpu_stim.txt", stim);
    n_ops     = count_ops();
    run_limit = (RESET_CYCLES + n_ops * (MAX_GAP + 1) + FPU_LATENCY + 20) * CLK_PERIOD;
    if (n_ops == 0) begin
      errors++;
      $display("no operations could be read from testbench/fpu_stim.txt");
    end else begin
      run_stimulus();
    end
    $display("%0d operations, %0d checks, %0d errors", n_ops, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (run_limit > 0);
    #(run_limit);
    $display("run timed out after %0d time units with %0d results still pending",
             run_limit, exp_q.size());
    $display("TEST FAILED");
    $finish;
  end

endmodule
